//--- hw/dadda_defs.svh
`ifndef DADDA_DEFS_SVH
`define DADDA_DEFS_SVH

// Operand and product sizes
`define DADDA_WIDTH   16
`define PRODUCT_WIDTH 32

// Bits per lookahead group in the final adder
`define CLA_GROUP     4

// Reduction stages for heights 13, 9, 6, 4, 3, 2
`define DADDA_STAGES  6

`endif

//--- hw/dadda_pkg.sv
`include "dadda_defs.svh"

package dadda_pkg;

    typedef logic [`DADDA_WIDTH-1:0] operand_t;

    typedef struct packed {
        operand_t a;
        operand_t b;
    } mul_operands_t;

    typedef logic [`PRODUCT_WIDTH-1:0] product_t;

    // One entry per product weight, bits packed at the low end
    typedef logic [`PRODUCT_WIDTH-1:0][`DADDA_WIDTH-1:0] col_matrix_t;

    typedef struct packed {
        product_t row_a;
        product_t row_b;
    } sum_rows_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Dadda height sequence, 2 3 4 6 9 13 counted from the last stage
    function automatic int stage_target(input int stage);
        int height;
        height = 2;
        for (int j = 0; j < `DADDA_STAGES - 1 - stage; j++) begin
            height = (height * 3) / 2;
        end
        return height;
    endfunction

    // Bits in a column before the given stage
    function automatic int column_height(input int stage, input int col);
        int heights [`PRODUCT_WIDTH];
        int carry;
        int total;
        int target;
        for (int k = 0; k < `PRODUCT_WIDTH; k++) begin
            if (k < `DADDA_WIDTH) begin
                heights[k] = k + 1;
            end else if (k < 2 * `DADDA_WIDTH - 1) begin
                heights[k] = 2 * `DADDA_WIDTH - 1 - k;
            end else begin
                heights[k] = 0;
            end
        end
        for (int s = 0; s < stage; s++) begin
            target = stage_target(s);
            carry  = 0;
            for (int k = 0; k < `PRODUCT_WIDTH; k++) begin
                total = heights[k] + carry;
                if (total > target) begin
                    carry      = (total - target) / 2 + (total - target) % 2; // One per FA or HA
                    heights[k] = target;
                end else begin
                    carry      = 0;
                    heights[k] = total;
                end
            end
        end
        return heights[col];
    endfunction

endpackage

//--- hw/pp_gen.sv
`include "dadda_defs.svh"

module pp_gen (
    input  dadda_pkg::mul_operands_t operands,
    output dadda_pkg::col_matrix_t   matrix
);

    logic [`DADDA_WIDTH-1:0][`DADDA_WIDTH-1:0] pp; // Row i is b gated by a[i]

    for (genvar i = 0; i < `DADDA_WIDTH; i++) begin : g_row
        assign pp[i] = operands.b & {`DADDA_WIDTH{operands.a[i]}};
    end

    // Column k collects pp[row][k-row], lowest row first
    for (genvar k = 0; k < `PRODUCT_WIDTH; k++) begin : g_col
        localparam int FIRST_ROW = (k >= `DADDA_WIDTH) ? k - `DADDA_WIDTH + 1 : 0;
        for (genvar n = 0; n < `DADDA_WIDTH; n++) begin : g_bit
            localparam int ROW = FIRST_ROW + n;
            if (ROW <= k && ROW < `DADDA_WIDTH) begin : g_pp
                assign matrix[k][n] = pp[ROW][k-ROW];
            end else begin : g_empty
                assign matrix[k][n] = 1'b0;
            end
        end
    end

endmodule

//--- hw/dadda_stage.sv
`include "dadda_defs.svh"

module dadda_stage #(
    parameter int STAGE = 0
) (
    input  dadda_pkg::col_matrix_t matrix_in,
    output dadda_pkg::col_matrix_t matrix_out
);
    import dadda_pkg::*;

    localparam int TARGET = stage_target(STAGE);

    // Carries leaving each column, FA carries first then the HA carry
    wire [`PRODUCT_WIDTH-1:0][`DADDA_WIDTH-1:0] carry_bits;

    // Carries that column col receives from the column below it
    function automatic int carries_into(input int col);
        int height;
        int cin;
        int excess;
        cin = 0;
        for (int k = 0; k < col; k++) begin
            height = column_height(STAGE, k);
            excess = (height + cin > TARGET) ? height + cin - TARGET : 0;
            cin    = excess / 2 + excess % 2;
        end
        return cin;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Per column reduction
    for (genvar k = 0; k < `PRODUCT_WIDTH; k++) begin : g_col
        localparam int HEIGHT = column_height(STAGE, k);
        localparam int CIN    = carries_into(k);
        localparam int EXCESS = (HEIGHT + CIN > TARGET) ? HEIGHT + CIN - TARGET : 0;
        localparam int NUM_FA = EXCESS / 2;
        localparam int NUM_HA = EXCESS % 2;
        localparam int NUM_SUM = NUM_FA + NUM_HA;
        localparam int USED    = 3 * NUM_FA + 2 * NUM_HA; // Inputs eaten by adders
        localparam int NUM_PASS = HEIGHT - USED;

        logic [`DADDA_WIDTH-1:0] col;
        logic [`DADDA_WIDTH-1:0] sums;
        logic [`DADDA_WIDTH-1:0] carries;

        assign col = matrix_in[k];

        for (genvar i = 0; i < `DADDA_WIDTH; i++) begin : g_bit
            // Adder slot i
            if (i < NUM_FA) begin : g_fa
                assign sums[i]    = col[3*i] ^ col[3*i+1] ^ col[3*i+2];
                assign carries[i] = (col[3*i] & col[3*i+1])
                                  | (col[3*i+2] & (col[3*i] ^ col[3*i+1]));
            end else if (i < NUM_SUM) begin : g_ha
                assign sums[i]    = col[3*NUM_FA] ^ col[3*NUM_FA+1];
                assign carries[i] = col[3*NUM_FA] & col[3*NUM_FA+1];
            end else begin : g_no_adder
                assign sums[i]    = 1'b0;
                assign carries[i] = 1'b0;
            end

            // Output slot i: sums, then untouched bits, then incoming carries
            if (i < NUM_SUM) begin : g_out_sum
                assign matrix_out[k][i] = sums[i];
            end else if (i < NUM_SUM + NUM_PASS) begin : g_out_pass
                assign matrix_out[k][i] = col[USED+i-NUM_SUM];
            end else if (i < NUM_SUM + NUM_PASS + CIN) begin : g_out_carry
                assign matrix_out[k][i] = carry_bits[k-1][i-NUM_SUM-NUM_PASS];
            end else begin : g_out_empty
                assign matrix_out[k][i] = 1'b0;
            end
        end

        assign carry_bits[k] = carries; // Top column carry is always zero
    end

endmodule

//--- hw/cla_block.sv
module cla_block #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             carry_in,
    output logic [WIDTH-1:0] sum,
    output logic             group_generate,
    output logic             group_propagate
);

    logic [WIDTH-1:0] gen;
    logic [WIDTH-1:0] prop;
    logic [WIDTH-1:0] carry;

    assign gen  = a & b;
    assign prop = a ^ b;

    // Flattened lookahead, every carry straight from carry_in
    always_comb begin
        logic term;
        for (int i = 0; i < WIDTH; i++) begin
            term = carry_in;
            for (int m = 0; m < i; m++) begin
                term = term & prop[m];
            end
            carry[i] = term;
            for (int j = 0; j < i; j++) begin
                term = gen[j];
                for (int m = j + 1; m < i; m++) begin
                    term = term & prop[m];
                end
                carry[i] = carry[i] | term;
            end
        end
    end

    // Group terms for the second level
    always_comb begin
        logic term;
        group_generate = 1'b0;
        for (int j = 0; j < WIDTH; j++) begin
            term = gen[j];
            for (int m = j + 1; m < WIDTH; m++) begin
                term = term & prop[m];
            end
            group_generate = group_generate | term;
        end
    end

    assign group_propagate = &prop;
    assign sum             = prop ^ carry;

endmodule

//--- hw/final_adder.sv
`include "dadda_defs.svh"

module final_adder (
    input  dadda_pkg::sum_rows_t rows,
    output dadda_pkg::product_t  product
);

    // Bits 1 and up split into 4-bit groups, the top group is whatever is left
    localparam int NUM_GROUPS = (`PRODUCT_WIDTH + `CLA_GROUP - 2) / `CLA_GROUP;

    logic                  bit0_carry;
    logic [NUM_GROUPS-1:0] group_gen;
    logic [NUM_GROUPS-1:0] group_prop;
    logic [NUM_GROUPS-1:0] group_carry;

    assign product[0]  = rows.row_a[0] ^ rows.row_b[0]; // Half add on bit 0
    assign bit0_carry  = rows.row_a[0] & rows.row_b[0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Second level lookahead over the groups
    always_comb begin
        logic term;
        for (int j = 0; j < NUM_GROUPS; j++) begin
            term = bit0_carry;
            for (int m = 0; m < j; m++) begin
                term = term & group_prop[m];
            end
            group_carry[j] = term;
            for (int i = 0; i < j; i++) begin
                term = group_gen[i];
                for (int m = i + 1; m < j; m++) begin
                    term = term & group_prop[m];
                end
                group_carry[j] = group_carry[j] | term;
            end
        end
    end

    for (genvar j = 0; j < NUM_GROUPS; j++) begin : g_group
        localparam int LSB   = 1 + j * `CLA_GROUP;
        localparam int WIDTH = (j == NUM_GROUPS - 1) ? `PRODUCT_WIDTH - LSB : `CLA_GROUP;

        cla_block #(
            .WIDTH(WIDTH)
        ) u_cla (
            .a              (rows.row_a[LSB +: WIDTH]),
            .b              (rows.row_b[LSB +: WIDTH]),
            .carry_in       (group_carry[j]),
            .sum            (product[LSB +: WIDTH]),
            .group_generate (group_gen[j]),
            .group_propagate(group_prop[j])
        );
    end

endmodule

//--- hw/dadda_multiplier_16.sv
`include "dadda_defs.svh"

module dadda_multiplier_16 (
    input  dadda_pkg::mul_operands_t operands,
    output dadda_pkg::product_t      product
);
    import dadda_pkg::*;

    col_matrix_t stage_matrix [`DADDA_STAGES+1]; // Entry s feeds stage s
    sum_rows_t   final_rows;

    pp_gen u_pp_gen (
        .operands(operands),
        .matrix  (stage_matrix[0])
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reduction down to two rows
    for (genvar s = 0; s < `DADDA_STAGES; s++) begin : g_stage
        dadda_stage #(
            .STAGE(s)
        ) u_stage (
            .matrix_in (stage_matrix[s]),
            .matrix_out(stage_matrix[s+1])
        );
    end

    for (genvar k = 0; k < `PRODUCT_WIDTH; k++) begin : g_rows
        assign final_rows.row_a[k] = stage_matrix[`DADDA_STAGES][k][0];
        assign final_rows.row_b[k] = stage_matrix[`DADDA_STAGES][k][1];
    end

    final_adder u_final_adder (
        .rows   (final_rows),
        .product(product)
    );

endmodule

//--- sim/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- sim/mul_checker.sv
module mul_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  dadda_pkg::mul_operands_t operands,
    input  dadda_pkg::product_t      product,
    input  logic                     vector_valid,
    input  logic                     expect_valid,
    input  dadda_pkg::product_t      expected,
    input  logic                     swapped,
    output int                       error_count,
    output int                       check_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import dadda_pkg::*;

    mul_operands_t last_operands;
    product_t      last_product;

    initial begin
        error_count   = 0;
        check_count   = 0;
        last_operands = '0;
        last_product  = '0;
    end

    // Plain unsigned 32-bit arithmetic
    function automatic product_t reference_product(input mul_operands_t ops);
        product_t wide_a;
        product_t wide_b;
        wide_a = ops.a; // Zero extended
        wide_b = ops.b;
        return wide_a * wide_b;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operands were driven one period ago, so both sides are settled here
    always @(posedge clk) begin
        product_t model;
        if (!reset && vector_valid) begin
            model       = reference_product(operands);
            check_count = check_count + 1;
            if (product !== model) begin
                $display("CHECK FAILED at %0t: a=%h b=%h expected %h, got %h",
                         $time, operands.a, operands.b, model, product);
                error_count = error_count + 1;
            end
            if (expect_valid && product !== expected) begin
                $display("CHECK FAILED at %0t: a=%h b=%h pattern expects %h, got %h",
                         $time, operands.a, operands.b, expected, product);
                error_count = error_count + 1;
            end
            if (swapped && product !== last_product) begin
                $display("CHECK FAILED at %0t: a=%h b=%h gave %h, swapped a=%h b=%h gave %h",
                         $time, operands.a, operands.b, product,
                         last_operands.a, last_operands.b, last_product);
                error_count = error_count + 1;
            end
            last_operands = operands;
            last_product  = product;
        end
    end

endmodule

//--- sim/tb_dadda_multiplier.sv
`include "dadda_defs.svh"

module tb_dadda_multiplier;
    timeunit 1ns;
    timeprecision 1ps;
    import dadda_pkg::*;

    localparam int RESET_CYCLES  = 10;
    localparam int PATTERN_COUNT = 38;
    localparam int WALK_COUNT    = 2 * `DADDA_WIDTH;
    localparam int RANDOM_COUNT  = 200;
    localparam int MARGIN        = 20;
    // Each random pair is applied twice, the second time swapped
    localparam int CYCLE_LIMIT   = RESET_CYCLES + PATTERN_COUNT + WALK_COUNT
                                 + 2 * RANDOM_COUNT + MARGIN;

    logic          clk;
    logic          reset;
    mul_operands_t operands;
    product_t      product;
    logic          vector_valid;
    logic          expect_valid;
    product_t      expected;
    logic          swapped;
    int            error_count;
    int            check_count;
    int            read_errors;
    int            seed;
    int            cycle_count = 0;
    logic [31:0]   pattern_mem [0:3*PATTERN_COUNT-1]; // a, b, product per vector

    tb_clock_gen #(
        .RESET_CYCLES(RESET_CYCLES)
    ) u_clock_gen (
        .clk  (clk),
        .reset(reset)
    );

    dadda_multiplier_16 uut (
        .operands(operands),
        .product (product)
    );

    mul_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .operands    (operands),
        .product     (product),
        .vector_valid(vector_valid),
        .expect_valid(expect_valid),
        .expected    (expected),
        .swapped     (swapped),
        .error_count (error_count),
        .check_count (check_count)
    );

    task automatic apply_vector(input operand_t a, input operand_t b, input logic has_expect,
                                input product_t value, input logic is_swap);
        @(posedge clk);
        operands.a   <= a;
        operands.b   <= b;
        vector_valid <= 1'b1;
        expect_valid <= has_expect;
        expected     <= value;
        swapped      <= is_swap;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    initial begin
        operand_t    rand_a;
        operand_t    rand_b;
        product_t    value;
        logic [31:0] rand_word;
        int          expected_checks;

        operands     = '0;
        vector_valid = 1'b0;
        expect_valid = 1'b0;
        expected     = '0;
        swapped      = 1'b0;
        read_errors  = 0;
        seed         = 17454;
        $readmemh("sim/mul_patterns.txt", pattern_mem);

        do begin
            @(posedge clk);
            operands <= '0; // Held at zero through reset
        end while (reset);

        for (int n = 0; n < PATTERN_COUNT; n++) begin
            if ($isunknown({pattern_mem[3*n], pattern_mem[3*n+1], pattern_mem[3*n+2]})) begin
                $display("Pattern vector %0d could not be read from the pattern file", n);
                read_errors++;
            end else begin
                apply_vector(pattern_mem[3*n][15:0], pattern_mem[3*n+1][15:0], 1'b1,
                             pattern_mem[3*n+2], 1'b0);
            end
        end

        // Walking one against a fixed operand gives a shifted copy of it
        for (int i = 0; i < `DADDA_WIDTH; i++) begin
            value = product_t'(16'hb6d3) << i;
            apply_vector(operand_t'(1) << i, 16'hb6d3, 1'b1, value, 1'b0);
        end
        for (int i = 0; i < `DADDA_WIDTH; i++) begin
            value = product_t'(16'h9e37) << i;
            apply_vector(16'h9e37, operand_t'(1) << i, 1'b1, value, 1'b0);
        end

        for (int n = 0; n < RANDOM_COUNT; n++) begin
            rand_word = $random(seed);
            rand_a    = rand_word[15:0];
            rand_word = $random(seed);
            rand_b    = rand_word[15:0];
            apply_vector(rand_a, rand_b, 1'b0, '0, 1'b0);
            apply_vector(rand_b, rand_a, 1'b0, '0, 1'b1);
        end

        @(posedge clk);
        vector_valid <= 1'b0;
        expect_valid <= 1'b0;
        swapped      <= 1'b0;
        @(posedge clk);

        expected_checks = PATTERN_COUNT - read_errors + WALK_COUNT + 2 * RANDOM_COUNT;
        if (check_count != expected_checks) begin
            $display("Only %0d of %0d vectors reached the checker", check_count, expected_checks);
        end
        $display("Summary: %0d mismatches, %0d unreadable vectors, %0d of %0d checks run",
                 error_count, read_errors, check_count, expected_checks);
        if (error_count == 0 && read_errors == 0 && check_count == expected_checks) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Timeout
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule

//--- flist.f
+incdir+hw
hw/dadda_pkg.sv
hw/pp_gen.sv
hw/dadda_stage.sv
hw/cla_block.sv
hw/final_adder.sv
hw/dadda_multiplier_16.sv
sim/tb_clock_gen.sv
sim/mul_checker.sv
sim/tb_dadda_multiplier.sv

//--- Bender.yml
package:
  name: dadda_multiplier_16

sources:
  - include_dirs:
      - hw
    files:
      - hw/dadda_pkg.sv
      - hw/pp_gen.sv
      - hw/dadda_stage.sv
      - hw/cla_block.sv
      - hw/final_adder.sv
      - hw/dadda_multiplier_16.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/tb_clock_gen.sv
      - sim/mul_checker.sv
      - sim/tb_dadda_multiplier.sv

//--- sim/mul_patterns.txt
// Columns: operand a, operand b, expected 32-bit product, all hex
// One vector per line
0000 0000 00000000
0000 ffff 00000000
ffff 0000 00000000
0001 0001 00000001
ffff 0001 0000ffff
0001 ffff 0000ffff
ffff ffff fffe0001
00ff 0101 0000ffff
8000 8000 40000000
8000 ffff 7fff8000
ffff 8000 7fff8000
0002 8000 00010000
00ff 00ff 0000fe01
0fff 0fff 00ffe001
ff00 ff00 fe010000
0100 0100 00010000
1000 1000 01000000
00ff 0100 0000ff00
ffff 0002 0001fffe
ffff 0101 0100feff
0101 0101 00010201
1111 1111 01234321
aaaa 5555 38e31c72
5555 aaaa 38e31c72
1234 0010 00012340
0010 1234 00012340
7fff 7fff 3fff0001
8001 8001 40010001
ffff fffe fffd0002
fffe ffff fffd0002
0003 5555 0000ffff
0f0f 0f0f 00e2c2e1
00ff 0001 000000ff
0001 8000 00008000
4000 0004 00010000
abcd 0001 0000abcd
ffff 00ff 00feff01
00ff ffff 00feff01
